//--- filelist.f
pic_pkg.sv
pic_command_regs.sv
pic_irq_channel.sv
pic_priority_resolver.sv
pic_ack_sequencer.sv
pic_top.sv
pic_checker.sv
tb_pic.sv

//--- Bender.yml
package:
  name: pic

sources:
  - pic_pkg.sv
  - pic_command_regs.sv
  - pic_irq_channel.sv
  - pic_priority_resolver.sv
  - pic_ack_sequencer.sv
  - pic_top.sv
  - target: test
    files:
      - pic_checker.sv
      - tb_pic.sv

//--- tb_pic.sv
// Testbench for the programmable interrupt controller.
// Drives bus writes, reads, interrupt lines and INTA pulses on the
// falling clock edge, with pic_checker comparing against its model.

`timescale 1ns/10ps
`default_nettype none

module tb_pic;

    logic       clock;
    logic       reset;
    logic       write_enable;
    logic       read_enable;
    logic       address;
    logic [7:0] data_in;
    logic [7:0] interrupt_request;
    logic       interrupt_acknowledge_n;
    logic [7:0] data_out;
    logic       data_out_enable;
    logic       interrupt_to_cpu;
    logic [7:0] sweep_mask;
    logic [7:0] sweep_request;
    int         checker_errors;
    int         tb_errors;
    integer     seed;

    pic_top i_dut (
        .clock                   (clock),
        .reset                   (reset),
        .write_enable            (write_enable),
        .read_enable             (read_enable),
        .address                 (address),
        .data_in                 (data_in),
        .interrupt_request       (interrupt_request),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .data_out                (data_out),
        .data_out_enable         (data_out_enable),
        .interrupt_to_cpu        (interrupt_to_cpu)
    );

    pic_checker i_checker (
        .clock                   (clock),
        .reset                   (reset),
        .write_enable            (write_enable),
        .read_enable             (read_enable),
        .address                 (address),
        .data_in                 (data_in),
        .interrupt_request       (interrupt_request),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .data_out                (data_out),
        .data_out_enable         (data_out_enable),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .error_count             (checker_errors)
    );

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        #2_000_000;
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clock);
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset = 1'b1;
        idle(10);
        reset = 1'b0;
    endtask

    task automatic write_reg(input logic addr, input logic [7:0] value);
        @(negedge clock);
        address      = addr;
        data_in      = value;
        write_enable = 1'b1;
        @(negedge clock);
        write_enable = 1'b0;
        data_in      = '0;
    endtask

    task automatic read_reg(input logic addr);
        @(negedge clock);
        address     = addr;
        read_enable = 1'b1;
        @(negedge clock);
        read_enable = 1'b0;
    endtask

    task automatic raise_irq(input logic [7:0] lines);
        @(negedge clock);
        interrupt_request = interrupt_request | lines;
    endtask

    task automatic lower_irq(input logic [7:0] lines);
        @(negedge clock);
        interrupt_request = interrupt_request & ~lines;
    endtask

    // Two INTA pulses, each low and high for at least 2 cycles
    task automatic inta_cycle();
        @(negedge clock);
        interrupt_acknowledge_n = 1'b0;
        idle(3);
        interrupt_acknowledge_n = 1'b1;
        idle(3);
        interrupt_acknowledge_n = 1'b0;
        idle(3);
        interrupt_acknowledge_n = 1'b1;
        idle(2);
    endtask

    task automatic wait_int(input logic level, input int max_cycles, output logic found);
        int count;
        found = 1'b0;
        count = 0;
        while (!found && count < max_cycles) begin
            @(negedge clock);
            count++;
            if (interrupt_to_cpu === level)
                found = 1'b1;
        end
    endtask

    task automatic expect_int(input logic level, input int max_cycles);
        logic found;
        wait_int(level, max_cycles, found);
        if (!found) begin
            $display("%0t: interrupt_to_cpu did not reach %0b within %0d cycles",
                     $time, level, max_cycles);
            tb_errors++;
        end
    endtask

    task automatic init_pic(input logic [7:0] icw1, input logic [7:0] icw4);
        write_reg(1'b0, icw1);
        write_reg(1'b1, 8'h40);
        write_reg(1'b1, icw4);
        write_reg(1'b1, 8'h00);
    endtask

    // Serve every pending interrupt with a non-specific EOI each
    task automatic drain_pending();
        logic found;
        int   served;
        found  = 1'b1;
        served = 0;
        while (found && served < 9) begin
            wait_int(1'b1, 6, found);
            if (found) begin
                inta_cycle();
                expect_int(1'b0, 4);
                write_reg(1'b0, 8'h20);
                served++;
            end
        end
        if (found) begin
            $display("%0t: pending interrupts did not drain", $time);
            tb_errors++;
        end
    endtask

    initial begin
        reset                   = 1'b1;
        write_enable            = 1'b0;
        read_enable             = 1'b0;
        address                 = 1'b0;
        data_in                 = '0;
        interrupt_request       = '0;
        interrupt_acknowledge_n = 1'b1;
        tb_errors               = 0;
        seed                    = 90;
        idle(10);
        reset = 1'b0;

        // All lines masked out of reset
        raise_irq(8'hff);
        idle(8);
        read_reg(1'b1);
        read_reg(1'b0);
        lower_irq(8'hff);
        apply_reset();

        init_pic(8'h13, 8'h01);
        raise_irq(8'h08);
        expect_int(1'b1, 4);
        inta_cycle();
        expect_int(1'b0, 4);
        lower_irq(8'h08);
        write_reg(1'b0, 8'h20);

        // Nesting, IRQ2 first and IRQ5 held off until EOI
        raise_irq(8'h24);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b0, 4);
        idle(8);
        write_reg(1'b0, 8'h20);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b0, 4);
        lower_irq(8'h24);
        write_reg(1'b0, 8'h20);

        write_reg(1'b1, 8'h40);
        raise_irq(8'h40);
        idle(8);
        read_reg(1'b1);
        read_reg(1'b0);
        lower_irq(8'h40);
        for (int n = 0; n < 10; n++) begin
            sweep_mask    = $random(seed);
            sweep_request = $random(seed);
            write_reg(1'b1, sweep_mask);
            interrupt_request = sweep_request;
            idle(3);
            interrupt_request = '0;
            drain_pending();
        end
        write_reg(1'b1, 8'h00);
        drain_pending();
        read_reg(1'b0);

        // AEOI serves IRQ4 after IRQ1 without an EOI write
        init_pic(8'h13, 8'h03);
        raise_irq(8'h12);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b1, 8);
        inta_cycle();
        expect_int(1'b0, 8);
        lower_irq(8'h12);

        init_pic(8'h1b, 8'h01);
        raise_irq(8'h80);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b0, 4);
        write_reg(1'b0, 8'h20);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b0, 4);
        lower_irq(8'h80);
        idle(3);
        write_reg(1'b0, 8'h20);
        idle(8);

        // Specific EOI of level 4 under level 1, then 2 and 6 follow
        init_pic(8'h13, 8'h01);
        raise_irq(8'h10);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b0, 4);
        raise_irq(8'h02);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b0, 4);
        raise_irq(8'h44);
        idle(8);
        write_reg(1'b0, 8'h64);
        idle(8);
        write_reg(1'b0, 8'h20);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b0, 4);
        write_reg(1'b0, 8'h20);
        expect_int(1'b1, 6);
        inta_cycle();
        expect_int(1'b0, 4);
        write_reg(1'b0, 8'h20);
        lower_irq(8'hff);
        idle(6);

        $display("Errors: checker %0d, testbench %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- pic_checker.sv
// Reference checker for the interrupt controller.
// Follows bus writes, interrupt lines and INTA pulses in a model of
// IMR, IRR and ISR, and compares reads, vectors and INT with the DUT.

`timescale 1ns/10ps
`default_nettype none

module pic_checker (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       write_enable,
    input  wire logic       read_enable,
    input  wire logic       address,
    input  wire logic [7:0] data_in,
    input  wire logic [7:0] interrupt_request,
    input  wire logic       interrupt_acknowledge_n,
    input  wire logic [7:0] data_out,
    input  wire logic       data_out_enable,
    input  wire logic       interrupt_to_cpu,
    output int              error_count
);

    logic [7:0] imr;
    logic [7:0] edge_irr;
    logic [7:0] irq_sample;
    logic [7:0] isr;
    logic [7:0] model_irr;
    logic [7:0] expected_data;
    logic [7:0] ack_vector;
    logic [8:0] choice;
    logic [4:0] base;
    logic       ltim;
    logic       ic4;
    logic       aeoi;
    logic       prev_inta;
    logic       expected_int;
    int         init_step;
    int         phase;
    int         ack_level;
    int         lowest;
    int         mismatch;

    // Bit 8 flags a winner, bits 7..0 hold the vector
    function automatic logic [8:0] expected_vector(input logic [7:0] irr, input logic [7:0] mask,
                                                   input logic [7:0] serv,
                                                   input logic [4:0] vbase);
        int limit;
        int winner;
        limit  = 8;
        winner = -1;
        for (int i = 7; i >= 0; i--) begin
            if (serv[i])
                limit = i;
        end
        for (int i = 7; i >= 0; i--) begin
            if (i < limit && irr[i] && !mask[i])
                winner = i;
        end
        if (winner < 0)
            return 9'h000;
        return {1'b1, vbase, 3'(winner)};
    endfunction

    task automatic report_value(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        $display("[ERROR] %0t %s expected %02h actual %02h", $time, name, expected, actual);
        error_count++;
    endtask

    initial error_count = 0;

    // Phase 0 idle, 1 first pulse low, 2 between pulses, 3 second pulse low
    always @(posedge clock) begin
        if (reset) begin
            imr        = 8'hff;
            edge_irr   = '0;
            irq_sample = '0;
            isr        = '0;
            base       = '0;
            ltim       = 1'b0;
            ic4        = 1'b0;
            aeoi       = 1'b0;
            prev_inta  = 1'b1;
            init_step  = 0;
            phase      = 0;
            mismatch   = 0;
            ack_vector = '0;
            ack_level  = 0;
        end else begin
            model_irr = ltim ? irq_sample : edge_irr;
            if (read_enable) begin
                expected_data = address ? imr : model_irr;
                if (data_out_enable !== 1'b1)
                    report_value("data_out_enable", 8'h01, {7'h00, data_out_enable});
                if (data_out !== expected_data)
                    report_value("data_out", expected_data, data_out);
            end
            if (prev_inta && !interrupt_acknowledge_n) begin
                if (phase == 0) begin
                    choice = expected_vector(model_irr, imr, isr, base);
                    if (!choice[8]) begin
                        $display("%0t: INTA started while no interrupt was pending", $time);
                        error_count++;
                    end else begin
                        ack_level           = choice[2:0];
                        ack_vector          = choice[7:0];
                        isr[ack_level]      = 1'b1;
                        edge_irr[ack_level] = 1'b0;
                    end
                    phase = 1;
                end else if (phase == 2) begin
                    phase = 3;
                end
            end else if (!prev_inta && interrupt_acknowledge_n) begin
                if (phase == 1) begin
                    phase = 2;
                end else if (phase == 3) begin
                    if (aeoi)
                        isr[ack_level] = 1'b0;
                    phase = 0;
                end
            end
            prev_inta = interrupt_acknowledge_n;
            if (phase == 3 && !interrupt_acknowledge_n) begin
                if (data_out_enable !== 1'b1)
                    report_value("data_out_enable", 8'h01, {7'h00, data_out_enable});
                if (data_out !== ack_vector)
                    report_value("data_out", ack_vector, data_out);
            end else if (!read_enable && data_out_enable !== 1'b0) begin
                report_value("data_out_enable", 8'h00, {7'h00, data_out_enable});
            end
            if (write_enable) begin
                if (!address && data_in[4]) begin
                    imr       = '0;
                    ltim      = data_in[3];
                    ic4       = data_in[0];
                    aeoi      = 1'b0;
                    init_step = 1;
                end else if (!address && init_step == 0 && !data_in[3]) begin
                    lowest = -1;
                    for (int i = 7; i >= 0; i--) begin
                        if (isr[i])
                            lowest = i;
                    end
                    if (data_in[6:5] == 2'b01 && lowest >= 0)
                        isr[lowest] = 1'b0;
                    else if (data_in[6:5] == 2'b11)
                        isr[data_in[2:0]] = 1'b0;
                end else if (address) begin
                    if (init_step == 1) begin
                        base      = data_in[7:3];
                        init_step = ic4 ? 2 : 0;
                    end else if (init_step == 2) begin
                        aeoi      = data_in[1];
                        init_step = 0;
                    end else begin
                        imr = data_in;
                    end
                end
            end
            edge_irr   = edge_irr | (interrupt_request & ~irq_sample);
            irq_sample = interrupt_request;
            // INT may trail the model by a few cycles of pipeline
            choice       = expected_vector(ltim ? irq_sample : edge_irr, imr, isr, base);
            expected_int = (phase != 0) || choice[8];
            if (interrupt_to_cpu !== expected_int)
                mismatch++;
            else
                mismatch = 0;
            if (mismatch == 5)
                report_value("interrupt_to_cpu", {7'h00, expected_int},
                             {7'h00, interrupt_to_cpu});
        end
    end

endmodule

`default_nettype wire

//--- pic_top.sv
// Programmable interrupt controller top level.
// Connects the command registers, eight interrupt channels, the
// priority resolver and the acknowledge sequencer.

`timescale 1ns/10ps
`default_nettype none

module pic_top (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           write_enable,
    input  wire logic                           read_enable,
    input  wire logic                           address,
    input  wire logic [pic_pkg::data_width-1:0] data_in,
    input  wire logic [pic_pkg::num_levels-1:0] interrupt_request,
    input  wire logic                           interrupt_acknowledge_n,
    output logic [pic_pkg::data_width-1:0]      data_out,
    output logic                                data_out_enable,
    output logic                                interrupt_to_cpu
);

    logic                                    level_triggered;
    logic [pic_pkg::num_levels-1:0]          interrupt_mask;
    logic [pic_pkg::data_width-pic_pkg::vector_base_lsb-1:0] vector_base;
    logic [pic_pkg::num_levels-1:0]          end_of_interrupt;
    logic [pic_pkg::data_width-1:0]          register_data;
    logic [pic_pkg::num_levels-1:0]          request;
    logic [pic_pkg::num_levels-1:0]          in_service;
    logic [pic_pkg::num_levels-1:0]          interrupt;
    logic [pic_pkg::num_levels-1:0]          highest_in_service;
    logic [pic_pkg::num_levels-1:0]          latch_in_service;
    logic                                    ack_done;
    logic [pic_pkg::num_levels-1:0]          acknowledged_level;

    pic_command_regs i_command_regs (
        .clock              (clock),
        .reset              (reset),
        .write_enable       (write_enable),
        .address            (address),
        .data_in            (data_in),
        .read_enable        (read_enable),
        .request            (request),
        .highest_in_service (highest_in_service),
        .ack_done           (ack_done),
        .acknowledged_level (acknowledged_level),
        .level_triggered    (level_triggered),
        .interrupt_mask     (interrupt_mask),
        .vector_base        (vector_base),
        .end_of_interrupt   (end_of_interrupt),
        .register_data      (register_data)
    );

    for (genvar i = 0; i < pic_pkg::num_levels; i++) begin : g_channel
        pic_irq_channel i_channel (
            .clock            (clock),
            .reset            (reset),
            .irq              (interrupt_request[i]),
            .level_triggered  (level_triggered),
            .latch_in_service (latch_in_service[i]),
            .end_of_interrupt (end_of_interrupt[i]),
            .request          (request[i]),
            .in_service       (in_service[i])
        );
    end

    pic_priority_resolver i_resolver (
        .request            (request),
        .interrupt_mask     (interrupt_mask),
        .in_service         (in_service),
        .interrupt          (interrupt),
        .highest_in_service (highest_in_service)
    );

    // Sequencer also owns the read mux
    pic_ack_sequencer i_ack_sequencer (
        .clock                   (clock),
        .reset                   (reset),
        .interrupt               (interrupt),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .vector_base             (vector_base),
        .register_data           (register_data),
        .read_enable             (read_enable),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .latch_in_service        (latch_in_service),
        .ack_done                (ack_done),
        .acknowledged_level      (acknowledged_level),
        .vector_data             (data_out),
        .vector_enable           (data_out_enable)
    );

endmodule

`default_nettype wire

//--- pic_ack_sequencer.sv
// Interrupt acknowledge sequencer.
// Raises INT, follows the two INTA pulses, latches the winner into
// service and drives the vector, or register data on reads.

`timescale 1ns/10ps
`default_nettype none

module pic_ack_sequencer (
    input  wire logic                                clock,
    input  wire logic                                reset,
    input  wire logic [pic_pkg::num_levels-1:0]      interrupt,
    input  wire logic                                interrupt_acknowledge_n,
    input  wire logic [pic_pkg::data_width-pic_pkg::vector_base_lsb-1:0] vector_base,
    input  wire logic [pic_pkg::data_width-1:0]      register_data,
    input  wire logic                                read_enable,
    output logic                                     interrupt_to_cpu,
    output logic [pic_pkg::num_levels-1:0]           latch_in_service,
    output logic                                     ack_done,
    output logic [pic_pkg::num_levels-1:0]           acknowledged_level,
    output logic [pic_pkg::data_width-1:0]           vector_data,
    output logic                                     vector_enable
);

    typedef enum logic [1:0] {st_idle, st_wait_ack, st_ack1, st_ack2} ack_state_t;

    ack_state_t state;
    ack_state_t state_next;

    logic inta_sync;
    logic inta_prev;
    logic inta_fall;
    logic inta_rise;
    logic vector_drive;

    always_ff @(posedge clock) begin
        if (reset) begin
            inta_sync <= 1'b1;
            inta_prev <= 1'b1;
        end else begin
            inta_sync <= interrupt_acknowledge_n;
            inta_prev <= inta_sync;
        end
    end

    assign inta_fall = inta_prev && !inta_sync;
    assign inta_rise = !inta_prev && inta_sync;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (interrupt != '0)
                    state_next = st_wait_ack;
            end
            st_wait_ack: begin
                // Request withdrawn before the CPU answered
                if (interrupt == '0)
                    state_next = st_idle;
                else if (inta_fall)
                    state_next = st_ack1;
            end
            st_ack1: begin
                if (inta_rise)
                    state_next = st_ack2;
            end
            default: begin
                if (inta_rise)
                    state_next = st_idle;
            end
        endcase
    end

    assign latch_in_service = (state == st_wait_ack && inta_fall) ? interrupt : '0;
    assign ack_done         = (state == st_ack2) && inta_rise;

    always_ff @(posedge clock) begin
        if (reset) begin
            state            <= st_idle;
            interrupt_to_cpu <= 1'b0;
        end else begin
            state            <= state_next;
            interrupt_to_cpu <= (state_next != st_idle);
        end
    end

    always_ff @(posedge clock) begin
        if (latch_in_service != '0)
            acknowledged_level <= latch_in_service;
    end

    // Vector only while the second pulse is low
    assign vector_drive = (state == st_ack2) && !interrupt_acknowledge_n;

    always_comb begin
        if (vector_drive)
            vector_data = {vector_base, pic_pkg::onehot_to_level(acknowledged_level)};
        else
            vector_data = register_data;
    end

    assign vector_enable = vector_drive || read_enable;

    assert property (@(posedge clock) disable iff (reset)
        vector_drive |-> $onehot(acknowledged_level))
        else $error("vector driven without a single acknowledged level");

endmodule

`default_nettype wire

//--- pic_priority_resolver.sv
// Fixed priority resolver, IR0 highest.
// Grants the highest unmasked request that outranks every level
// currently in service.

`timescale 1ns/10ps
`default_nettype none

module pic_priority_resolver (
    input  wire logic [pic_pkg::num_levels-1:0] request,
    input  wire logic [pic_pkg::num_levels-1:0] interrupt_mask,
    input  wire logic [pic_pkg::num_levels-1:0] in_service,
    output logic [pic_pkg::num_levels-1:0]      interrupt,
    output logic [pic_pkg::num_levels-1:0]      highest_in_service
);

    logic [pic_pkg::num_levels-1:0] unmasked;
    logic [pic_pkg::num_levels-1:0] outranks;
    logic [pic_pkg::num_levels-1:0] eligible;

    assign unmasked = request & ~interrupt_mask;

    // Lowest set bit of in_service
    assign highest_in_service = in_service & -in_service;

    // Levels numbered below every in-service level, all when none is
    assign outranks = ~(in_service | -in_service);
    assign eligible = unmasked & outranks;

    // Lowest eligible level wins
    assign interrupt = eligible & -eligible;

    always_comb begin
        assert final ($onehot0(interrupt))
            else $error("more than one grant");
    end

endmodule

`default_nettype wire

//--- pic_irq_channel.sv
// Interrupt line channel.
// Edge or level trigger detection, the request bit and the
// in-service bit of one line.

`timescale 1ns/10ps
`default_nettype none

module pic_irq_channel (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic irq,
    input  wire logic level_triggered,
    input  wire logic latch_in_service,
    input  wire logic end_of_interrupt,
    output logic      request,
    output logic      in_service
);

    logic irq_sync;
    logic irq_prev;
    logic edge_request;

    always_ff @(posedge clock) begin
        if (reset) begin
            irq_sync <= 1'b0;
            irq_prev <= 1'b0;
        end else begin
            irq_sync <= irq;
            irq_prev <= irq_sync;
        end
    end

    // New edge wins over a clear in the same cycle
    always_ff @(posedge clock) begin
        if (reset)
            edge_request <= 1'b0;
        else if (irq_sync && !irq_prev)
            edge_request <= 1'b1;
        else if (latch_in_service)
            edge_request <= 1'b0;
    end

    assign request = level_triggered ? irq_sync : edge_request;

    always_ff @(posedge clock) begin
        if (reset)
            in_service <= 1'b0;
        else if (latch_in_service)
            in_service <= 1'b1;
        else if (end_of_interrupt)
            in_service <= 1'b0;
    end

    assert property (@(posedge clock) disable iff (reset)
        !(latch_in_service && end_of_interrupt))
        else $error("latch and EOI on the same line");

endmodule

`default_nettype wire

//--- pic_command_regs.sv
// Command register block.
// Decodes host writes, runs the ICW1/ICW2/ICW4 sequence, holds the
// configuration and mask, and issues end-of-interrupt pulses.

`timescale 1ns/10ps
`default_nettype none

module pic_command_regs (
    input  wire logic                                clock,
    input  wire logic                                reset,
    input  wire logic                                write_enable,
    input  wire logic                                address,
    input  wire logic [pic_pkg::data_width-1:0]      data_in,
    input  wire logic                                read_enable,
    input  wire logic [pic_pkg::num_levels-1:0]      request,
    input  wire logic [pic_pkg::num_levels-1:0]      highest_in_service,
    input  wire logic                                ack_done,
    input  wire logic [pic_pkg::num_levels-1:0]      acknowledged_level,
    output logic                                     level_triggered,
    output logic [pic_pkg::num_levels-1:0]           interrupt_mask,
    output logic [pic_pkg::data_width-pic_pkg::vector_base_lsb-1:0] vector_base,
    output logic [pic_pkg::num_levels-1:0]           end_of_interrupt,
    output logic [pic_pkg::data_width-1:0]           register_data
);

    typedef enum logic [1:0] {st_ready, st_wait_icw2, st_wait_icw4} init_state_t;

    init_state_t state;

    logic single_mode;
    logic icw4_needed;
    logic auto_eoi;
    logic icw1_write;
    logic ocw2_write;
    logic addr1_write;
    logic [pic_pkg::num_levels-1:0] eoi_next;

    assign icw1_write  = write_enable && !address && data_in[pic_pkg::icw1_flag_bit];
    assign ocw2_write  = write_enable && !address && (state == st_ready)
                         && !data_in[pic_pkg::icw1_flag_bit] && !data_in[pic_pkg::ocw_flag_bit];
    assign addr1_write = write_enable && address;

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= st_ready;
            level_triggered <= 1'b0;
            single_mode     <= 1'b1;
            icw4_needed     <= 1'b0;
            auto_eoi        <= 1'b0;
            vector_base     <= '0;
            interrupt_mask  <= pic_pkg::mask_reset_value;
        end else if (icw1_write) begin
            // Restart initialization
            state           <= st_wait_icw2;
            level_triggered <= data_in[pic_pkg::icw1_bit_ltim];
            single_mode     <= data_in[pic_pkg::icw1_bit_sngl];
            icw4_needed     <= data_in[pic_pkg::icw1_bit_ic4];
            auto_eoi        <= 1'b0;
            interrupt_mask  <= '0;
        end else if (addr1_write) begin
            case (state)
                st_wait_icw2: begin
                    vector_base <= data_in[pic_pkg::data_width-1:pic_pkg::vector_base_lsb];
                    state       <= icw4_needed ? st_wait_icw4 : st_ready;
                end
                st_wait_icw4: begin
                    auto_eoi <= data_in[pic_pkg::icw4_bit_aeoi];
                    state    <= st_ready;
                end
                default: begin
                    // OCW1
                    interrupt_mask <= data_in;
                end
            endcase
        end
    end

    // EOI source select, AEOI merged in at the end of acknowledge
    always_comb begin
        eoi_next = '0;
        if (ocw2_write) begin
            case (data_in[pic_pkg::ocw2_eoi_field_lsb +: 2])
                pic_pkg::ocw2_nonspecific_eoi: eoi_next = highest_in_service;
                pic_pkg::ocw2_specific_eoi:
                    eoi_next = pic_pkg::level_to_onehot(
                        data_in[pic_pkg::ocw2_level_lsb +: pic_pkg::level_width]);
                default: eoi_next = '0;
            endcase
        end
        if (auto_eoi && ack_done)
            eoi_next = eoi_next | acknowledged_level;
    end

    always_ff @(posedge clock) begin
        if (reset)
            end_of_interrupt <= '0;
        else
            end_of_interrupt <= eoi_next;
    end

    // IRR at address 0, IMR at address 1
    assign register_data = !read_enable ? '0 : (address ? interrupt_mask : request);

    assert property (@(posedge clock) reset |-> !write_enable)
        else $error("write strobe during reset");

    // Only single mode is built, cascade setup is a host error
    assert property (@(posedge clock) disable iff (reset) (state == st_ready) |-> single_mode)
        else $error("cascade mode programmed");

endmodule

`default_nettype wire

//--- pic_pkg.sv
// Shared definitions for the programmable interrupt controller.
// Bus and level widths, reset values, command word bit positions
// and level encoding helpers.

`default_nettype none

package pic_pkg;

    localparam int num_levels  = 8;
    localparam int data_width  = 8;
    localparam int level_width = 3;

    // All lines masked out of reset
    localparam logic [num_levels-1:0] mask_reset_value = 8'hff;

    // ICW1
    localparam int icw1_bit_ic4  = 0;
    localparam int icw1_bit_sngl = 1;
    localparam int icw1_bit_ltim = 3;
    localparam int icw1_flag_bit = 4;

    // OCW2
    localparam int ocw2_level_lsb     = 0;
    localparam int ocw2_eoi_field_lsb = 5;
    localparam logic [1:0] ocw2_nonspecific_eoi = 2'b01;
    localparam logic [1:0] ocw2_specific_eoi    = 2'b11;

    localparam int icw4_bit_aeoi = 1;
    localparam int ocw_flag_bit  = 3;

    // ICW2 bits 7..3 form the upper vector bits
    localparam int vector_base_lsb = 3;

    function automatic logic [num_levels-1:0] level_to_onehot(input logic [level_width-1:0] level);
        logic [num_levels-1:0] onehot;
        onehot = '0;
        onehot[level] = 1'b1;
        return onehot;
    endfunction

    function automatic logic [level_width-1:0] onehot_to_level(input logic [num_levels-1:0] onehot);
        logic [level_width-1:0] level;
        level = '0;
        for (int i = 0; i < num_levels; i++) begin
            if (onehot[i])
                level = level_width'(i);
        end
        return level;
    endfunction

endpackage

`default_nettype wire
